// File: logic/core_pkg.sv
// Shared widths, word types and encodings for the stack processor core.
// Every RTL module that needs a type or an opcode imports this package.
`default_nettype none

package core_pkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	localparam int DATA_W    = 16;
	localparam int IADDR_W   = 9;
	localparam int DADDR_W   = 9;
	localparam int PORT_W    = 3;
	localparam int OPCODE_W  = 7;
	localparam int OPERAND_W = 9;
	localparam int INSTR_W   = OPCODE_W + OPERAND_W;

	// Stack sizes in entries
	localparam int DATA_DEPTH = 16;
	localparam int CALL_DEPTH = 8;

	// ------------------------------------------------------------------------
	// Word types
	// ------------------------------------------------------------------------
	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic [IADDR_W-1:0]       iaddr_t;
	typedef logic [DADDR_W-1:0]       daddr_t;
	typedef logic [PORT_W-1:0]        port_t;
	typedef logic [OPERAND_W-1:0]     operand_t;
	// Opcode in the top bits, operand in the low bits
	typedef logic [INSTR_W-1:0]       instr_t;

	// ------------------------------------------------------------------------
	// Encodings
	// ------------------------------------------------------------------------
	// Opcodes 8..11 and 16 upward are free and execute as NOP
	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP = 7'd0,
		OP_LDC = 7'd1,
		OP_LOD = 7'd2,
		OP_SET = 7'd3,
		OP_INN = 7'd4,
		OP_OUT = 7'd5,
		OP_ALU = 7'd6,
		OP_HLT = 7'd7,
		OP_JMP = 7'd12,
		OP_JIZ = 7'd13,
		OP_CAL = 7'd14,
		OP_RET = 7'd15
	} opcode_e;

	// ALU operation, taken from operand[3:0] of the ALU opcode
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_XOR, ALU_SHL,
		ALU_SHR, ALU_LES, ALU_EQU, ALU_NEG, ALU_INV
	} alu_op_e;

	// Source of the next accumulator value
	typedef enum logic [2:0] {
		SRC_KEEP, SRC_CONST, SRC_MEM, SRC_IO, SRC_ALU, SRC_POP
	} acc_src_e;

endpackage

`default_nettype wire

// File: logic/lifo_stack.sv
// Register-array LIFO stack with a combinational top output.
// Serves as the call stack and as the data stack of the core.
`default_nettype none

module lifo_stack #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 16
) (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             push,
	input  wire logic             pop,
	input  wire logic [WIDTH-1:0] din,
	output logic      [WIDTH-1:0] top
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Entry storage
	logic [WIDTH-1:0] mem [DEPTH];

	// Pointer to the next free entry
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] top_idx;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + PTR_W'(1);
		end else if (pop) begin
			ptr <= ptr - PTR_W'(1);
		end
	end

	// Write at the free slot
	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Top is the last written entry
	assign top_idx = ptr - PTR_W'(1);
	assign top     = mem[top_idx];

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
// Program counter with next-address selection and the subroutine call stack.
// The decoder steers it with branch, call, ret and hold.
`default_nettype none

module fetch_unit
	import core_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   branch,
	input  wire logic   call,
	input  wire logic   ret,
	input  wire logic   hold,
	input  wire iaddr_t target,
	output iaddr_t      pc
);

	iaddr_t pc_inc;
	iaddr_t pc_next;
	iaddr_t ret_addr;

	assign pc_inc = pc + IADDR_W'(1);

	// ------------------------------------------------------------------------
	// Call stack
	// ------------------------------------------------------------------------
	// Return address is the word after the CAL
	lifo_stack #(
		.WIDTH(IADDR_W),
		.DEPTH(CALL_DEPTH)
	) call_stack_i (
		.clk (clk),
		.rst (rst),
		.push(call),
		.pop (ret),
		.din (pc_inc),
		.top (ret_addr)
	);

	// ------------------------------------------------------------------------
	// Next address
	// ------------------------------------------------------------------------
	always_comb begin
		if (hold) begin
			pc_next = pc;
		end else if (ret) begin
			pc_next = ret_addr;
		end else if (branch || call) begin
			pc_next = target;
		end else begin
			pc_next = pc_inc;
		end
	end

	// Restart from address 0
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
// Combinational instruction decoder of the core.
// Maps the opcode to ALU, stack, accumulator, memory, I/O and branch controls.
`default_nettype none

module instr_decoder
	import core_pkg::*;
(
	input  wire logic   rst,
	input  wire instr_t instr,
	input  wire logic   acc_zero,
	output alu_op_e     alu_op,
	output acc_src_e    acc_src,
	output logic        push,
	output logic        pop,
	output logic        mem_wr,
	output logic        req_in,
	output logic        out_en,
	output logic        branch,
	output logic        call,
	output logic        ret,
	output logic        hold
);

	opcode_e opcode;

	assign opcode = opcode_e'(instr[INSTR_W-1 -: OPCODE_W]);
	// ALU operation sits in the low operand bits
	assign alu_op = alu_op_e'(instr[3:0]);

	always_comb begin
		// Defaults give a NOP
		acc_src = SRC_KEEP;
		push    = 1'b0;
		pop     = 1'b0;
		mem_wr  = 1'b0;
		req_in  = 1'b0;
		out_en  = 1'b0;
		branch  = 1'b0;
		call    = 1'b0;
		ret     = 1'b0;
		hold    = 1'b0;

		// Nothing strobes while in reset
		if (!rst) begin
			case (opcode)
				OP_LDC: begin
					push    = 1'b1;
					acc_src = SRC_CONST;
				end
				OP_LOD: begin
					push    = 1'b1;
					acc_src = SRC_MEM;
				end
				// Store acc, then refill it from the stack
				OP_SET: begin
					mem_wr  = 1'b1;
					pop     = 1'b1;
					acc_src = SRC_POP;
				end
				OP_INN: begin
					req_in  = 1'b1;
					push    = 1'b1;
					acc_src = SRC_IO;
				end
				OP_OUT: begin
					out_en  = 1'b1;
					pop     = 1'b1;
					acc_src = SRC_POP;
				end
				OP_ALU: begin
					acc_src = SRC_ALU;
					// Two-input ops consume the second-of-stack
					if (alu_op <= ALU_EQU) begin
						pop = 1'b1;
					end
				end
				OP_HLT: hold = 1'b1;
				OP_JMP: branch = 1'b1;
				// JIZ pops nothing so acc stays for the next test
				OP_JIZ: branch = acc_zero;
				OP_CAL: call = 1'b1;
				OP_RET: ret = 1'b1;
				// NOP and unused codes keep the defaults
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/alu.sv
// Combinational integer ALU of the core.
// Combines the second-of-stack with the accumulator, or acts on acc alone.
`default_nettype none

module alu
	import core_pkg::*;
(
	input  wire alu_op_e op,
	input  wire data_t   nos,
	input  wire data_t   acc,
	output data_t        result
);

	// Shift amount from the low acc bits
	logic [3:0] shamt;

	assign shamt = acc[3:0];

	always_comb begin
		case (op)
			// ----------------------------------------------------------------
			// Arithmetic
			// ----------------------------------------------------------------
			ALU_ADD: result = nos + acc;
			ALU_SUB: result = nos - acc;
			ALU_NEG: result = -acc;

			// ----------------------------------------------------------------
			// Bitwise
			// ----------------------------------------------------------------
			ALU_AND: result = nos & acc;
			ALU_ORR: result = nos | acc;
			ALU_XOR: result = nos ^ acc;
			ALU_INV: result = ~acc;

			// Logical shifts, zero fill
			ALU_SHL: result = nos << shamt;
			ALU_SHR: result = data_t'($unsigned(nos) >> shamt);

			// ----------------------------------------------------------------
			// Compares
			// ----------------------------------------------------------------
			// Signed compare, 1 or 0
			ALU_LES: result = (nos < acc) ? data_t'(1) : data_t'(0);
			ALU_EQU: result = (nos == acc) ? data_t'(1) : data_t'(0);

			// Unused codes leave acc as is
			default: result = acc;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/acc_path.sv
// Accumulator register with its next-value select and the data stack.
// The accumulator is the stack top, so a push saves the old acc below it.
`default_nettype none

module acc_path
	import core_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire acc_src_e acc_src,
	input  wire logic     push,
	input  wire logic     pop,
	input  wire operand_t operand,
	input  wire data_t    mem_data,
	input  wire data_t    io_in,
	input  wire data_t    alu_result,
	output data_t         acc,
	output data_t         nos
);

	data_t const_ext;
	data_t acc_next;

	// Constant from the operand, sign extended
	assign const_ext = {{(DATA_W - OPERAND_W){operand[OPERAND_W-1]}}, operand};

	// ------------------------------------------------------------------------
	// Data stack
	// ------------------------------------------------------------------------
	lifo_stack #(
		.WIDTH(DATA_W),
		.DEPTH(DATA_DEPTH)
	) data_stack_i (
		.clk (clk),
		.rst (rst),
		.push(push),
		.pop (pop),
		.din (acc),
		.top (nos)
	);

	// ------------------------------------------------------------------------
	// Accumulator
	// ------------------------------------------------------------------------
	always_comb begin
		case (acc_src)
			SRC_CONST: acc_next = const_ext;
			SRC_MEM:   acc_next = mem_data;
			SRC_IO:    acc_next = io_in;
			SRC_ALU:   acc_next = alu_result;
			SRC_POP:   acc_next = nos;
			default:   acc_next = acc;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/stack_core.sv
// Top level of the single-cycle stack processor core.
// Connects fetch, decoder, ALU and accumulator path to memory and I/O ports.
`default_nettype none

module stack_core
	import core_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	// Instruction memory, async read
	input  wire instr_t instr,
	output iaddr_t      instr_addr,
	// Data memory
	output logic        mem_wr,
	output daddr_t      mem_addr,
	input  wire data_t  mem_data_in,
	output data_t       mem_data_out,
	// Input port
	input  wire data_t  io_in,
	output logic        req_in,
	output port_t       addr_in,
	// Output port
	output logic        out_en,
	output port_t       addr_out,
	output data_t       io_out
);

	operand_t operand;
	alu_op_e  alu_op;
	acc_src_e acc_src;
	logic     push;
	logic     pop;
	logic     branch;
	logic     call;
	logic     ret;
	logic     hold;
	data_t    acc;
	data_t    nos;
	data_t    alu_result;

	// Operand feeds branch target, memory address and both ports
	assign operand      = instr[OPERAND_W-1:0];
	assign mem_addr     = operand[DADDR_W-1:0];
	assign addr_in      = operand[PORT_W-1:0];
	assign addr_out     = operand[PORT_W-1:0];
	assign mem_data_out = acc;
	assign io_out       = acc;

	// ------------------------------------------------------------------------
	// Fetch and decode
	// ------------------------------------------------------------------------
	fetch_unit fetch_i (
		.clk   (clk),
		.rst   (rst),
		.branch(branch),
		.call  (call),
		.ret   (ret),
		.hold  (hold),
		.target(operand[IADDR_W-1:0]),
		.pc    (instr_addr)
	);

	instr_decoder dec_i (
		.rst     (rst),
		.instr   (instr),
		.acc_zero(acc == '0),
		.alu_op  (alu_op),
		.acc_src (acc_src),
		.push    (push),
		.pop     (pop),
		.mem_wr  (mem_wr),
		.req_in  (req_in),
		.out_en  (out_en),
		.branch  (branch),
		.call    (call),
		.ret     (ret),
		.hold    (hold)
	);

	// ------------------------------------------------------------------------
	// Execute
	// ------------------------------------------------------------------------
	alu alu_i (
		.op    (alu_op),
		.nos   (nos),
		.acc   (acc),
		.result(alu_result)
	);

	acc_path acc_i (
		.clk       (clk),
		.rst       (rst),
		.acc_src   (acc_src),
		.push      (push),
		.pop       (pop),
		.operand   (operand),
		.mem_data  (mem_data_in),
		.io_in     (io_in),
		.alu_result(alu_result),
		.acc       (acc),
		.nos       (nos)
	);

endmodule

`default_nettype wire

// File: sim/core_model.svh
// Reference model of the core's instruction set, included in the testbench module.
// Runs the image in rom and fills the expected output, write and input lists.
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// RAM contents after reset, distinct for every address
function automatic data_t ram_fill(input int a);
	return data_t'((a * 291) ^ 16'h5a5a);
endfunction

// Integer operations on second-of-stack a and accumulator b
function automatic data_t alu_ref(input logic [3:0] f, input data_t a, input data_t b);
	case (f)
		ALU_ADD: return a + b;
		ALU_SUB: return a - b;
		ALU_AND: return a & b;
		ALU_ORR: return a | b;
		ALU_XOR: return a ^ b;
		ALU_SHL: return a << b[3:0];
		// Zero fill from the top
		ALU_SHR: return data_t'($unsigned(a) >> b[3:0]);
		ALU_LES: return ($signed(a) < $signed(b)) ? 16'sd1 : 16'sd0;
		ALU_EQU: return (a == b) ? 16'sd1 : 16'sd0;
		ALU_NEG: return -b;
		ALU_INV: return ~b;
		default: return b;
	endcase
endfunction

// Executes from address 0 until HLT and returns the cycle count
function automatic int run_model();
	data_t      acc;
	data_t      nos;
	data_t      dstk [DATA_DEPTH];
	iaddr_t     cstk [CALL_DEPTH];
	data_t      mem [512];
	int         dsp;
	int         csp;
	int         cycles;
	iaddr_t     pc;
	logic [6:0] op;
	logic [8:0] opd;
	bit         halted;

	exp_out.delete();
	exp_wr.delete();
	exp_req.delete();
	for (int a = 0; a < 512; a++) begin
		mem[a] = ram_fill(a);
	end
	acc = '0;
	dsp = 0;
	csp = 0;
	pc = '0;
	cycles = 0;
	halted = 1'b0;
	while (!halted && cycles < MODEL_LIMIT) begin
		op = rom[pc][15:9];
		opd = rom[pc][8:0];
		nos = (dsp > 0) ? dstk[dsp-1] : '0;
		cycles++;
		pc++;
		case (op)
			OP_LDC, OP_LOD, OP_INN: begin
				// Old acc moves down the stack
				dstk[dsp] = acc;
				dsp++;
				if (op == OP_LDC) begin
					acc = data_t'($signed(opd));
				end else if (op == OP_LOD) begin
					acc = mem[opd];
				end else begin
					acc = io_table[opd[2:0]];
					exp_req.push_back({29'd0, opd[2:0]});
				end
			end
			OP_SET, OP_OUT: begin
				if (op == OP_SET) begin
					mem[opd] = acc;
					exp_wr.push_back({7'd0, opd, acc});
				end else begin
					exp_out.push_back({13'd0, opd[2:0], acc});
				end
				acc = nos;
				dsp--;
			end
			OP_ALU: begin
				acc = alu_ref(opd[3:0], nos, acc);
				// ADD through EQU take two inputs
				if (opd[3:0] <= ALU_EQU) begin
					dsp--;
				end
			end
			OP_HLT: begin
				pc--;
				halted = 1'b1;
			end
			OP_JMP: pc = opd;
			OP_JIZ: begin
				if (acc == 0) begin
					pc = opd;
				end
			end
			OP_CAL: begin
				cstk[csp] = pc;
				csp++;
				pc = opd;
			end
			OP_RET: begin
				csp--;
				pc = cstk[csp];
			end
			default: ;
		endcase
	end
	return cycles;
endfunction

`endif

// File: sim/tb_stack_core.sv
// Testbench for the stack processor core with ROM, RAM and I/O port models.
// Five programs are built, predicted by the reference model, then run and checked.
`default_nettype none

module tb_stack_core
	import core_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 5;
	localparam int MARGIN       = 6;
	localparam int NUM_PROGS    = 5;
	localparam int ROM_WORDS    = 512;
	localparam int MODEL_LIMIT  = 4000;

	logic   clk = 1'b0;
	logic   rst = 1'b1;
	instr_t instr;
	iaddr_t instr_addr;
	logic   mem_wr;
	daddr_t mem_addr;
	data_t  mem_data_in;
	data_t  mem_data_out;
	data_t  io_in = '0;
	logic   req_in;
	port_t  addr_in;
	logic   out_en;
	port_t  addr_out;
	data_t  io_out;

	// Memory and port models
	instr_t rom [ROM_WORDS];
	instr_t images [NUM_PROGS][ROM_WORDS];
	data_t  ram [512];
	data_t  io_table [8];

	// Expected events and progress through them
	logic [31:0] exp_out [$];
	logic [31:0] exp_wr [$];
	logic [31:0] exp_req [$];
	int          out_idx;
	int          wr_idx;
	int          req_idx;
	logic        active = 1'b0;

	int          errors = 0;
	int          checks = 0;
	int          wp;
	int          budget;
	logic        budget_ready = 1'b0;

	`include "core_model.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	stack_core dut_i (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.mem_wr      (mem_wr),
		.mem_addr    (mem_addr),
		.mem_data_in (mem_data_in),
		.mem_data_out(mem_data_out),
		.io_in       (io_in),
		.req_in      (req_in),
		.addr_in     (addr_in),
		.out_en      (out_en),
		.addr_out    (addr_out),
		.io_out      (io_out)
	);

	// ------------------------------------------------------------------------
	// Memory and port models
	// ------------------------------------------------------------------------
	assign instr       = rom[instr_addr];
	assign mem_data_in = ram[mem_addr];

	// RAM reloads while in reset
	always @(posedge clk) begin
		if (rst) begin
			for (int a = 0; a < 512; a++) begin
				ram[a] <= ram_fill(a);
			end
		end else if (mem_wr) begin
			ram[mem_addr] <= mem_data_out;
		end
	end

	// Input port answers on the falling edge for the port in addr_in
	always @(negedge clk) begin
		io_in <= io_table[addr_in];
	end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0d ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic emit(input opcode_e op, input int opd);
		rom[wp] = {op, 9'(opd)};
		wp++;
	endtask

	// ------------------------------------------------------------------------
	// Program images
	// ------------------------------------------------------------------------
	task automatic build_program(input int p);
		int addrs [6];
		int k;

		for (int a = 0; a < ROM_WORDS; a++) begin
			rom[a] = '0;
		end
		wp = 0;
		case (p)
			// Every ALU op twice with equal EQU inputs on the second pass
			0: for (int pass = 0; pass < 2; pass++) begin
				for (int f = 0; f <= 10; f++) begin
					k = int'($urandom % 512);
					emit(OP_LDC, k);
					if (f <= 8) begin
						emit(OP_LDC, (pass == 1 && f == 8) ? k : int'($urandom % 512));
					end
					emit(OP_ALU, f);
					emit(OP_OUT, 0);
				end
			end
			// Stores followed by loads in reverse order
			1: begin
				for (int i = 0; i < 6; i++) begin
					addrs[i] = int'($urandom % 512);
					emit(OP_LDC, int'($urandom % 512));
					emit(OP_SET, addrs[i]);
				end
				for (int i = 5; i >= 0; i--) begin
					emit(OP_LOD, addrs[i]);
					emit(OP_OUT, 1);
				end
			end
			// Pairs of input reads summed and sent to port 2
			2: for (int i = 0; i < 4; i++) begin
				emit(OP_INN, int'($urandom % 8));
				emit(OP_INN, int'($urandom % 8));
				emit(OP_ALU, ALU_ADD);
				emit(OP_OUT, 2);
			end
			// Countdown held in RAM word 20 that exits to HLT at 10
			3: begin
				emit(OP_LDC, 3 + int'($urandom % 5));
				emit(OP_SET, 20);
				emit(OP_LOD, 20);
				emit(OP_JIZ, 10);
				emit(OP_LOD, 20);
				emit(OP_OUT, 3);
				emit(OP_LDC, 1);
				emit(OP_ALU, ALU_SUB);
				emit(OP_SET, 20);
				emit(OP_JMP, 2);
			end
			// Three nested subroutines of six words each from address 4
			default: begin
				emit(OP_CAL, 4);
				emit(OP_LDC, 40);
				emit(OP_OUT, 5);
				emit(OP_HLT, 0);
				for (int lvl = 1; lvl <= 3; lvl++) begin
					emit(OP_LDC, lvl);
					emit(OP_OUT, 5);
					// Innermost runs an unused opcode instead of a call
					emit((lvl < 3) ? OP_CAL : opcode_e'(7'd9), wp + 4);
					emit(OP_LDC, 10 + lvl);
					emit(OP_OUT, 5);
					emit(OP_RET, 0);
				end
			end
		endcase
		emit(OP_HLT, 0);
	endtask

	// ------------------------------------------------------------------------
	// Reset and run
	// ------------------------------------------------------------------------
	// Address 0 shows each strobing opcode in turn while rst is high
	task automatic apply_reset();
		opcode_e strobe_ops [3] = '{OP_SET, OP_OUT, OP_INN};
		instr_t  first;

		first = rom[0];
		rst = 1'b1;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			if (i < 3) begin
				rom[0] = {strobe_ops[i], 9'd0};
			end else begin
				rom[0] = first;
			end
			@(negedge clk);
			check_value("pc in reset", instr_addr, 0);
			check_value("strobes in reset", {mem_wr, req_in, out_en}, 0);
		end
		rom[0] = first;
		rst = 1'b0;
	endtask

	task automatic run_program(input int p);
		int cycles;

		@(negedge clk);
		rst = 1'b1;
		for (int a = 0; a < ROM_WORDS; a++) begin
			rom[a] = images[p][a];
		end
		cycles = run_model();
		out_idx = 0;
		wr_idx = 0;
		req_idx = 0;
		apply_reset();
		active = 1'b1;
		repeat (cycles + MARGIN) @(negedge clk);
		active = 1'b0;
		check_value($sformatf("output count, program %0d", p), out_idx, exp_out.size());
		check_value($sformatf("write count, program %0d", p), wr_idx, exp_wr.size());
		check_value($sformatf("input count, program %0d", p), req_idx, exp_req.size());
	endtask

	// Each strobe against the next expected event
	always @(posedge clk) begin
		if (active) begin
			if (out_en) begin
				if (out_idx < exp_out.size()) begin
					check_value("output event", {13'd0, addr_out, io_out}, exp_out[out_idx]);
				end
				out_idx++;
			end
			if (mem_wr) begin
				if (wr_idx < exp_wr.size()) begin
					check_value("memory write", {7'd0, mem_addr, mem_data_out}, exp_wr[wr_idx]);
				end
				wr_idx++;
			end
			if (req_in) begin
				if (req_idx < exp_req.size()) begin
					check_value("input port", {29'd0, addr_in}, exp_req[req_idx]);
				end
				req_idx++;
			end
		end
	end

	initial begin
		wait (budget_ready);
		#(budget * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", budget);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		// One seed for every random value of the run
		void'($urandom(32'h21ef));
		for (int i = 0; i < 8; i++) begin
			io_table[i] = data_t'($urandom);
		end
		// All images first so the run length is known up front
		budget = 0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			build_program(p);
			for (int a = 0; a < ROM_WORDS; a++) begin
				images[p][a] = rom[a];
			end
			budget += run_model() + RESET_CYCLES + MARGIN + 1;
		end
		budget *= 2;
		budget_ready = 1'b1;
		for (int p = 0; p < NUM_PROGS; p++) begin
			run_program(p);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
logic/core_pkg.sv
logic/lifo_stack.sv
logic/fetch_unit.sv
logic/instr_decoder.sv
logic/alu.sv
logic/acc_path.sv
logic/stack_core.sv
sim/tb_stack_core.sv

// File: Makefile
# Verilator build, run, lint and clean for the stack processor core

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_stack_core
RTL_TOP   ?= stack_core
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= >>> PASS

RTL_SRCS := $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Fails unless the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
